//--- rvfi_pkg.sv
// ---------------------------------------------------------------------------
// Retire port types for an RV32 core and the RV32I encoding fields
// used by the trace decoder
// ---------------------------------------------------------------------------

package rvfi_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_mask_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // One retired instruction, RVFI subset
  typedef struct packed {
    logic       valid;
    insn_t      insn;
    xlen_t      pc_rdata;
    xlen_t      pc_wdata;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    xlen_t      mem_addr;
    byte_mask_t mem_rmask;
    byte_mask_t mem_wmask;
  } rvfi_rec_t;

  // Major opcodes, instruction bits 6:0
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  // Low bits of every 32-bit instruction
  localparam logic [1:0] OPC_UNCOMPRESSED = 2'b11;

  // funct7 values that RV32I allows
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // funct3 values with a special meaning in the decoder
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_PRIV    = 3'b000;
  localparam funct3_t F3_FENCE   = 3'b000;
  localparam funct3_t F3_FENCE_I = 3'b001;

endpackage

//--- trace_pkg.sv
// ---------------------------------------------------------------------------
// Trace record, instruction classes, access mask, queue depth and the
// Wishbone register map of the trace monitor
// ---------------------------------------------------------------------------

package trace_pkg;

  typedef enum logic [3:0] {
    CLS_OP         = 4'd0,
    CLS_OP_IMM     = 4'd1,
    CLS_SHIFT_IMM  = 4'd2,
    CLS_LUI        = 4'd3,
    CLS_AUIPC      = 4'd4,
    CLS_JAL        = 4'd5,
    CLS_JALR       = 4'd6,
    CLS_BRANCH     = 4'd7,
    CLS_LOAD       = 4'd8,
    CLS_STORE      = 4'd9,
    CLS_CSR        = 4'd10,
    CLS_FENCE      = 4'd11,
    CLS_SYSTEM     = 4'd12,
    CLS_COMPRESSED = 4'd13,
    CLS_INVALID    = 4'd14
  } insn_class_e;

  // Data items touched by one instruction
  typedef logic [3:0] access_mask_t;
  localparam access_mask_t ACC_RS1 = 4'b0001;
  localparam access_mask_t ACC_RS2 = 4'b0010;
  localparam access_mask_t ACC_RD  = 4'b0100;
  localparam access_mask_t ACC_MEM = 4'b1000;

  typedef logic [31:0] cycle_t;

  typedef struct packed {
    insn_class_e        cls;
    rvfi_pkg::insn_t    insn;
    rvfi_pkg::xlen_t    pc_rdata;
    rvfi_pkg::xlen_t    pc_wdata;
    rvfi_pkg::reg_addr_t rs1;
    rvfi_pkg::reg_addr_t rs2;
    rvfi_pkg::reg_addr_t rd;
    cycle_t             cycle;
  } decoded_t;

  typedef struct packed {
    cycle_t              cycle;
    rvfi_pkg::xlen_t     pc;
    insn_class_e         cls;
    access_mask_t        mask;
    rvfi_pkg::reg_addr_t rd;
    rvfi_pkg::reg_addr_t rs1;
    rvfi_pkg::reg_addr_t rs2;
    rvfi_pkg::xlen_t     operand;
  } trace_rec_t;

  // Record queue
  localparam int unsigned TRACE_DEPTH = 8;
  localparam int unsigned PTR_W       = $clog2(TRACE_DEPTH);
  localparam int unsigned CNT_W       = $clog2(TRACE_DEPTH + 1);
  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] count_t;

  // Word offsets of the bus registers
  typedef logic [2:0] wb_adr_t;
  localparam wb_adr_t REG_STATUS  = 3'd0;
  localparam wb_adr_t REG_CYCLE   = 3'd1;
  localparam wb_adr_t REG_PC      = 3'd2;
  localparam wb_adr_t REG_INFO    = 3'd3;
  localparam wb_adr_t REG_OPERAND = 3'd4;
  localparam wb_adr_t REG_POP     = 3'd5;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    wb_adr_t         adr;
    rvfi_pkg::xlen_t dat;
  } wb_req_t;

endpackage

//--- trace_decode.sv
// ---------------------------------------------------------------------------
// Retire stage of the trace monitor: cycle counter, RV32I classification
// and the registered decoded record
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module trace_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rvfi_pkg::rvfi_rec_t rvfi,
  output trace_pkg::decoded_t dec,
  output logic                dec_valid
);

  import rvfi_pkg::*;
  import trace_pkg::*;

  cycle_t      cycle_q;
  insn_class_e cls;
  opcode_t     opcode;
  funct3_t     funct3;
  funct7_t     funct7;

  assign opcode = rvfi.insn[6:0];
  assign funct3 = rvfi.insn[14:12];
  assign funct7 = rvfi.insn[31:25];

  // Free running, zero in the first cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_comb begin
    cls = CLS_INVALID;
    if (rvfi.insn[1:0] != OPC_UNCOMPRESSED) begin
      cls = CLS_COMPRESSED;
    end else begin
      case (opcode)
        OPC_OP: begin
          // SUB and SRA are the only users of the alternate funct7
          if (funct7 == F7_BASE) begin
            cls = CLS_OP;
          end else if (funct7 == F7_ALT &&
                       (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)) begin
            cls = CLS_OP;
          end
        end
        OPC_OP_IMM: begin
          if (funct3 == F3_SLL) begin
            if (funct7 == F7_BASE) begin
              cls = CLS_SHIFT_IMM;
            end
          end else if (funct3 == F3_SRL_SRA) begin
            if (funct7 == F7_BASE || funct7 == F7_ALT) begin
              cls = CLS_SHIFT_IMM;
            end
          end else begin
            cls = CLS_OP_IMM;
          end
        end
        OPC_LUI:   cls = CLS_LUI;
        OPC_AUIPC: cls = CLS_AUIPC;
        OPC_JAL:   cls = CLS_JAL;
        OPC_JALR: begin
          if (funct3 == 3'b000) begin
            cls = CLS_JALR;
          end
        end
        OPC_BRANCH: begin
          if (funct3 != 3'b010 && funct3 != 3'b011) begin
            cls = CLS_BRANCH;
          end
        end
        OPC_LOAD: begin
          // Sizes 3, 6 and 7 do not exist
          if (funct3 != 3'b011 && funct3 < 3'b110) begin
            cls = CLS_LOAD;
          end
        end
        OPC_STORE: begin
          if (funct3 <= 3'b010) begin
            cls = CLS_STORE;
          end
        end
        OPC_MISC_MEM: begin
          if (funct3 == F3_FENCE || funct3 == F3_FENCE_I) begin
            cls = CLS_FENCE;
          end
        end
        OPC_SYSTEM: begin
          if (funct3 == F3_PRIV) begin
            cls = CLS_SYSTEM;
          end else if (funct3 != 3'b100) begin
            cls = CLS_CSR;
          end
        end
        default: cls = CLS_INVALID;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= rvfi.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi.valid) begin
      dec.cls      <= cls;
      dec.insn     <= rvfi.insn;
      dec.pc_rdata <= rvfi.pc_rdata;
      dec.pc_wdata <= rvfi.pc_wdata;
      dec.rs1      <= rvfi.rs1_addr;
      dec.rs2      <= rvfi.rs2_addr;
      dec.rd       <= rvfi.rd_addr;
      dec.cycle    <= cycle_q;
    end
  end

  // A retired word must always leave with a defined class
  a_cls_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid |-> !$isunknown(dec.cls));

endmodule

//--- trace_execute.sv
// ---------------------------------------------------------------------------
// Operand and access mask per instruction class, and the registered
// trace record
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module trace_execute (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  trace_pkg::decoded_t   dec,
  input  logic                  dec_valid,
  output trace_pkg::trace_rec_t rec,
  output logic                  rec_valid
);

  import rvfi_pkg::*;
  import trace_pkg::*;

  xlen_t        imm_i;
  xlen_t        imm_s;
  xlen_t        imm_b;
  xlen_t        operand;
  access_mask_t mask;

  // Immediate formats
  assign imm_i = {{20{dec.insn[31]}}, dec.insn[31:20]};
  assign imm_s = {{20{dec.insn[31]}}, dec.insn[31:25], dec.insn[11:7]};
  assign imm_b = {{19{dec.insn[31]}}, dec.insn[31], dec.insn[7],
                  dec.insn[30:25], dec.insn[11:8], 1'b0};

  always_comb begin
    operand = '0;
    mask    = '0;
    case (dec.cls)
      CLS_OP: begin
        mask = ACC_RS1 | ACC_RS2 | ACC_RD;
      end
      CLS_OP_IMM, CLS_JALR: begin
        operand = imm_i;
        mask    = ACC_RS1 | ACC_RD;
      end
      CLS_SHIFT_IMM: begin
        operand = {27'b0, dec.insn[24:20]};
        mask    = ACC_RS1 | ACC_RD;
      end
      CLS_LUI, CLS_AUIPC: begin
        operand = {12'b0, dec.insn[31:12]};
        mask    = ACC_RD;
      end
      CLS_JAL: begin
        // Jump target is already known from the core
        operand = dec.pc_wdata;
        mask    = ACC_RD;
      end
      CLS_BRANCH: begin
        // Taken target, pc_wdata only holds it when the branch was taken
        operand = dec.pc_rdata + imm_b;
        mask    = ACC_RS1 | ACC_RS2;
      end
      CLS_LOAD: begin
        operand = imm_i;
        mask    = ACC_RS1 | ACC_RD | ACC_MEM;
      end
      CLS_STORE: begin
        operand = imm_s;
        mask    = ACC_RS1 | ACC_RS2 | ACC_MEM;
      end
      CLS_CSR: begin
        operand = {20'b0, dec.insn[31:20]};
        mask    = ACC_RD;
        // Immediate forms take a zimm in the rs1 field
        if (!dec.insn[14]) begin
          mask = mask | ACC_RS1;
        end
      end
      CLS_FENCE: begin
        operand = {24'b0, dec.insn[27:20]};
      end
      default: begin
        operand = '0;
        mask    = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid) begin
      rec.cycle   <= dec.cycle;
      rec.pc      <= dec.pc_rdata;
      rec.cls     <= dec.cls;
      rec.mask    <= mask;
      rec.rd      <= dec.rd;
      rec.rs1     <= dec.rs1;
      rec.rs2     <= dec.rs2;
      rec.operand <= operand;
    end
  end

  // Only memory instructions report a memory access
  a_mem_only_ldst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rec_valid && (rec.mask & ACC_MEM) != '0) |-> rec.cls inside {CLS_LOAD, CLS_STORE});

endmodule

//--- trace_result.sv
// ---------------------------------------------------------------------------
// Trace record queue with sticky overflow, and the Wishbone classic
// register port that reads and pops it
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module trace_result (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  trace_pkg::trace_rec_t rec,
  input  logic                  rec_valid,
  input  trace_pkg::wb_req_t    wb,
  output rvfi_pkg::xlen_t       wb_dat,
  output logic                  wb_ack
);

  import rvfi_pkg::*;
  import trace_pkg::*;

  trace_rec_t mem [TRACE_DEPTH];
  trace_rec_t head;
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  count_t     count_q;
  logic       overflow_q;
  logic       empty;
  logic       full;
  logic       bus_req;
  logic       do_pop;
  logic       do_push;
  logic       ovf_clr;
  xlen_t      rdata;
  xlen_t      rdata_q;

  assign empty = (count_q == '0);
  assign full  = (count_q == count_t'(TRACE_DEPTH));
  assign head  = mem[rd_ptr_q];

  // New bus cycle, not yet acknowledged
  assign bus_req = wb.cyc && wb.stb && !wb_ack;
  assign do_pop  = bus_req && wb.we && wb.adr == REG_POP && !empty;
  assign ovf_clr = bus_req && wb.we && wb.adr == REG_STATUS;

  // A pop in the same cycle frees the slot for the push
  assign do_push = rec_valid && (!full || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(TRACE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(TRACE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Lost record wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overflow_q <= 1'b0;
    end else if (rec_valid && !do_push) begin
      overflow_q <= 1'b1;
    end else if (ovf_clr) begin
      overflow_q <= 1'b0;
    end
  end

  always_comb begin
    rdata = '0;
    case (wb.adr)
      REG_STATUS: begin
        rdata[CNT_W-1:0] = count_q;
        rdata[8]         = overflow_q;
      end
      REG_CYCLE:   rdata = empty ? '0 : head.cycle;
      REG_PC:      rdata = empty ? '0 : head.pc;
      REG_INFO: begin
        if (!empty) begin
          rdata = {3'b000, head.rs2, 3'b000, head.rs1, 3'b000, head.rd,
                   head.mask, head.cls};
        end
      end
      REG_OPERAND: rdata = empty ? '0 : head.operand;
      default:     rdata = '0;
    endcase
  end

  // Single cycle ack, data captured with it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= bus_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req) begin
      rdata_q <= rdata;
    end
  end

  assign wb_dat = rdata_q;

  a_count_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= count_t'(TRACE_DEPTH));

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack |-> (wb.cyc && wb.stb));

endmodule

//--- rvfi_tracer_top.sv
// ---------------------------------------------------------------------------
// Trace monitor top: retire port, three stage pipeline and bus port
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module rvfi_tracer_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rvfi_pkg::rvfi_rec_t rvfi,
  input  trace_pkg::wb_req_t  wb,
  output rvfi_pkg::xlen_t     wb_dat,
  output logic                wb_ack
);

  import trace_pkg::*;

  decoded_t   dec;
  logic       dec_valid;
  trace_rec_t rec;
  logic       rec_valid;

  trace_decode i_decode (
    .clk_i,
    .rst_ni,
    .rvfi,
    .dec,
    .dec_valid
  );

  trace_execute i_execute (
    .clk_i,
    .rst_ni,
    .dec,
    .dec_valid,
    .rec,
    .rec_valid
  );

  trace_result i_result (
    .clk_i,
    .rst_ni,
    .rec,
    .rec_valid,
    .wb,
    .wb_dat,
    .wb_ack
  );

endmodule

//--- tb_rvfi_tracer_tests.svh
// ---------------------------------------------------------------------------
// Directed tests of the trace monitor: reset state, ALU, control flow,
// memory and system classes, cycle stamps and overflow
// ---------------------------------------------------------------------------

`ifndef TB_RVFI_TRACER_TESTS_SVH
`define TB_RVFI_TRACER_TESTS_SVH

task automatic after_reset_test();
  xlen_t data;
  repeat (4) begin
    @(negedge clk_i);
    if (wb_ack !== 1'b0) begin
      $display("Wishbone ack is high without any bus request");
      abort_run();
    end
  end
  wb_read(REG_STATUS, data);
  check_word("STATUS after reset", data, status_word(0, 1'b0));
endtask

task automatic alu_test();
  logic [11:0] imm;
  funct3_t     f3;
  xlen_t       pc;
  for (int i = 0; i < 4; i++) begin
    imm = 12'($random(seed));
    f3  = funct3_t'($random(seed));
    pc  = xlen_t'($random(seed)) & ~32'h3;
    retire_and_check(CLS_OP, r_type(F7_BASE, rnd_reg(), rnd_reg(), f3, rnd_reg(), OPC_OP),
                     pc, pc + 4);
    retire_and_check(CLS_OP, r_type(F7_ALT, rnd_reg(), rnd_reg(), 3'b000, rnd_reg(), OPC_OP),
                     pc, pc + 4);
    // Shift funct3 values turned into SLTI
    if (f3 == 3'b001 || f3 == 3'b101) begin
      f3 = 3'b010;
    end
    retire_and_check(CLS_OP_IMM, i_type(imm, rnd_reg(), f3, rnd_reg(), OPC_OP_IMM), pc, pc + 4);
    retire_and_check(CLS_SHIFT_IMM, i_type({F7_BASE, imm[4:0]}, rnd_reg(), 3'b001, rnd_reg(),
                     OPC_OP_IMM), pc, pc + 4);
    retire_and_check(CLS_SHIFT_IMM, i_type({F7_ALT, imm[4:0]}, rnd_reg(), 3'b101, rnd_reg(),
                     OPC_OP_IMM), pc, pc + 4);
    retire_and_check(CLS_LUI, u_type(20'($random(seed)), rnd_reg(), OPC_LUI), pc, pc + 4);
    retire_and_check(CLS_AUIPC, u_type(20'($random(seed)), rnd_reg(), OPC_AUIPC), pc, pc + 4);
  end
endtask

task automatic flow_test();
  logic [12:0] off;
  funct3_t     f3;
  xlen_t       pc;
  pc = 32'h0000_4000;
  retire_and_check(CLS_BRANCH, b_type(13'h1ff0, 5'd3, 5'd4, 3'b000), pc, pc + 4);
  retire_and_check(CLS_BRANCH, b_type(13'h07fc, 5'd5, 5'd6, 3'b101), pc, pc + 32'h7fc);
  retire_and_check(CLS_BRANCH, b_type(13'h1000, 5'd7, 5'd8, 3'b111), pc, pc - 32'h1000);
  for (int i = 0; i < 3; i++) begin
    off = 13'($random(seed)) & 13'h1ffe;
    f3  = funct3_t'($random(seed));
    // BLT instead of the two unused branch codes
    if (f3[2:1] == 2'b01) begin
      f3 = 3'b100;
    end
    retire_and_check(CLS_BRANCH, b_type(off, rnd_reg(), rnd_reg(), f3), pc, pc + 4);
  end
  retire_and_check(CLS_JAL, j_type(21'h0_0800, 5'd1), pc, pc + 32'h800);
  retire_and_check(CLS_JAL, j_type(21'h1f_fff0, 5'd0), pc, pc - 32'd16);
  retire_and_check(CLS_JALR, i_type(12'hffc, 5'd1, 3'b000, 5'd0, OPC_JALR), pc,
                   32'h0000_8000);
  retire_and_check(CLS_JALR, i_type(12'($random(seed)), rnd_reg(), 3'b000, rnd_reg(),
                   OPC_JALR), pc, 32'h0000_9000);
endtask

task automatic mem_sys_test();
  funct3_t ld_sizes[5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  xlen_t   pc;
  pc = 32'h0001_0000;
  foreach (ld_sizes[i]) begin
    retire_and_check(CLS_LOAD, i_type(12'($random(seed)), rnd_reg(), ld_sizes[i], rnd_reg(),
                     OPC_LOAD), pc, pc + 4);
  end
  for (int i = 0; i < 3; i++) begin
    retire_and_check(CLS_STORE, s_type(12'h800 + 12'(i * 5), rnd_reg(), rnd_reg(), 3'(i)),
                     pc, pc + 4);
  end
  retire_and_check(CLS_STORE, s_type(12'h07f, 5'd9, 5'd2, 3'b010), pc, pc + 4);
  retire_and_check(CLS_INVALID, i_type(12'h010, 5'd2, 3'b011, 5'd5, OPC_LOAD), pc, pc + 4);
  retire_and_check(CLS_INVALID, s_type(12'h010, 5'd5, 5'd2, 3'b011), pc, pc + 4);
  // CSRRW reads rs1 and CSRRSI carries a zimm in that field
  retire_and_check(CLS_CSR, i_type(12'h300, 5'd10, 3'b001, 5'd11, OPC_SYSTEM), pc, pc + 4);
  retire_and_check(CLS_CSR, i_type(12'hc00, 5'd7, 3'b110, 5'd12, OPC_SYSTEM), pc, pc + 4);
  retire_and_check(CLS_FENCE, i_type(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM), pc, pc + 4);
  retire_and_check(CLS_FENCE, i_type({4'b0, 8'($random(seed))}, 5'd0, 3'b000, 5'd0,
                   OPC_MISC_MEM), pc, pc + 4);
  retire_and_check(CLS_SYSTEM, 32'h0000_0073, pc, 32'h0000_0100);
  retire_and_check(CLS_COMPRESSED, 32'h0000_4501, pc, pc + 2);
endtask

task automatic stamp_test();
  int unsigned gaps[3] = '{1, 2, 5};
  insn_t       insns[4];
  cycle_t      stamps[4];
  cycle_t      seen[4];
  for (int i = 0; i < 4; i++) begin
    insns[i] = i_type(12'(i), 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM);
    retire(insns[i], 32'h100 + 32'(4 * i), 32'h104 + 32'(4 * i), stamps[i]);
    if (i < 3) begin
      repeat (gaps[i] - 1) @(negedge clk_i);
    end
  end
  wait_status(status_word(4, 1'b0));
  for (int i = 0; i < 4; i++) begin
    expect_head(CLS_OP_IMM, insns[i], 32'h100 + 32'(4 * i), 32'h104 + 32'(4 * i), stamps[i],
                seen[i]);
  end
  for (int i = 1; i < 4; i++) begin
    check_cycle("stamp gap", seen[i] - seen[i - 1], cycle_t'(gaps[i - 1]));
  end
endtask

task automatic overflow_test();
  insn_t  insns[TRACE_DEPTH + 3];
  cycle_t stamps[TRACE_DEPTH + 3];
  cycle_t seen;
  xlen_t  data;
  for (int i = 0; i < TRACE_DEPTH + 3; i++) begin
    insns[i] = i_type(12'($random(seed)), rnd_reg(), 3'b100, rnd_reg(), OPC_OP_IMM);
    retire(insns[i], 32'h2000 + 32'(4 * i), 32'h2004 + 32'(4 * i), stamps[i]);
  end
  wait_status(status_word(TRACE_DEPTH, 1'b1));
  for (int i = 0; i < TRACE_DEPTH; i++) begin
    expect_head(CLS_OP_IMM, insns[i], 32'h2000 + 32'(4 * i), 32'h2004 + 32'(4 * i),
                stamps[i], seen);
  end
  wb_read(REG_STATUS, data);
  check_word("STATUS after drain", data, status_word(0, 1'b1));
  // Head registers and POP read zero while the queue is empty
  for (int a = REG_CYCLE; a <= REG_POP; a++) begin
    wb_read(wb_adr_t'(a), data);
    check_word("empty queue read", data, '0);
  end
  wb_write(REG_STATUS, '0);
  wb_read(REG_STATUS, data);
  check_word("STATUS after clear", data, status_word(0, 1'b0));
  // Pop on an empty queue
  wb_write(REG_POP, '0);
  wb_read(REG_STATUS, data);
  check_word("STATUS after empty pop", data, status_word(0, 1'b0));
endtask

`endif

//--- tb_rvfi_tracer.sv
// ---------------------------------------------------------------------------
// Testbench for the trace monitor: clock and reset, retire driver,
// Wishbone master tasks, reference model and compare tasks
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_rvfi_tracer;

  import rvfi_pkg::*;
  import trace_pkg::*;

  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 40;

  logic      clk_i;
  logic      rst_ni;
  rvfi_rec_t rvfi;
  wb_req_t   wb;
  xlen_t     wb_dat;
  logic      wb_ack;
  cycle_t    tb_cycle;
  integer    seed;

  rvfi_tracer_top i_dut (
    .clk_i,
    .rst_ni,
    .rvfi,
    .wb,
    .wb_dat,
    .wb_ack
  );

  always #4 clk_i = ~clk_i;

  // Cycles since reset with the same origin as the stamp
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tb_cycle <= '0;
    end else begin
      tb_cycle <= tb_cycle + 1;
    end
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_class(input string what, input insn_class_e got, input insn_class_e exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s class %0d, expected %s", $time, what, got, exp.name());
      abort_run();
    end
  endtask

  task automatic check_mask(input string what, input access_mask_t got, input access_mask_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s mask %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cycle(input string what, input cycle_t got, input cycle_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Instruction encoders with immediates given as in the ISA manual
  function automatic insn_t r_type(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd, opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t i_type(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic insn_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic insn_t u_type(logic [19:0] imm, reg_addr_t rd, opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic insn_t j_type(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic reg_addr_t rnd_reg();
    return reg_addr_t'($random(seed));
  endfunction

  function automatic xlen_t status_word(int count, logic ovf);
    return {23'b0, ovf, 4'b0, 4'(count)};
  endfunction

  // Reference model of the access mask table
  function automatic access_mask_t model_mask(insn_class_e cls, insn_t insn);
    case (cls)
      CLS_OP:                              return ACC_RS1 | ACC_RS2 | ACC_RD;
      CLS_OP_IMM, CLS_SHIFT_IMM, CLS_JALR: return ACC_RS1 | ACC_RD;
      CLS_LUI, CLS_AUIPC, CLS_JAL:         return ACC_RD;
      CLS_BRANCH:                          return ACC_RS1 | ACC_RS2;
      CLS_LOAD:                            return ACC_RS1 | ACC_RD | ACC_MEM;
      CLS_STORE:                           return ACC_RS1 | ACC_RS2 | ACC_MEM;
      CLS_CSR:                             return insn[14] ? ACC_RD : (ACC_RD | ACC_RS1);
      default:                             return '0;
    endcase
  endfunction

  // Reference model of the operand table
  function automatic xlen_t model_operand(insn_class_e cls, insn_t insn, xlen_t pc,
                                          xlen_t pc_next);
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    imm_i = 32'($signed(insn[31:20]));
    imm_s = 32'($signed({insn[31:25], insn[11:7]}));
    imm_b = 32'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
    case (cls)
      CLS_OP_IMM, CLS_JALR, CLS_LOAD: return imm_i;
      CLS_SHIFT_IMM:                  return {27'b0, insn[24:20]};
      CLS_LUI, CLS_AUIPC:             return {12'b0, insn[31:12]};
      CLS_JAL:                        return pc_next;
      CLS_BRANCH:                     return pc + imm_b;
      CLS_STORE:                      return imm_s;
      CLS_CSR:                        return {20'b0, insn[31:20]};
      CLS_FENCE:                      return {24'b0, insn[27:20]};
      default:                        return '0;
    endcase
  endfunction

  // One retired instruction with register fields taken from the encoding
  task automatic retire(input insn_t insn, input xlen_t pc, input xlen_t pc_next,
                        output cycle_t stamp);
    rvfi.valid     = 1'b1;
    rvfi.insn      = insn;
    rvfi.pc_rdata  = pc;
    rvfi.pc_wdata  = pc_next;
    rvfi.rs1_addr  = insn[19:15];
    rvfi.rs2_addr  = insn[24:20];
    rvfi.rd_addr   = insn[11:7];
    rvfi.mem_addr  = '0;
    rvfi.mem_rmask = '0;
    rvfi.mem_wmask = '0;
    stamp          = tb_cycle;
    @(negedge clk_i);
    rvfi.valid = 1'b0;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack && n < ACK_TIMEOUT);
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack within %0d cycles", ACK_TIMEOUT);
      abort_run();
    end
  endtask

  // Request held until ack has dropped again
  task automatic wb_read(input wb_adr_t adr, output xlen_t data);
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we  = 1'b0;
    wb.adr = adr;
    wb.dat = '0;
    wait_ack();
    data = wb_dat;
    @(negedge clk_i);
    wb = '0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input xlen_t data);
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we  = 1'b1;
    wb.adr = adr;
    wb.dat = data;
    wait_ack();
    @(negedge clk_i);
    wb = '0;
  endtask

  task automatic wait_status(input xlen_t expected);
    xlen_t data;
    int    polls;
    polls = 0;
    wb_read(REG_STATUS, data);
    while (data !== expected && polls < POLL_LIMIT) begin
      wb_read(REG_STATUS, data);
      polls++;
    end
    if (data !== expected) begin
      $display("Timeout: STATUS stayed at %h while waiting for %h", data, expected);
      abort_run();
    end
  endtask

  // Reads the head record, compares it with the model and pops it
  task automatic expect_head(input insn_class_e cls, input insn_t insn, input xlen_t pc,
                             input xlen_t pc_next, input cycle_t stamp, output cycle_t seen);
    xlen_t        data;
    xlen_t        info;
    access_mask_t mask;
    mask = model_mask(cls, insn);
    info = {3'b0, insn[24:20], 3'b0, insn[19:15], 3'b0, insn[11:7], mask, cls};
    wb_read(REG_CYCLE, data);
    seen = cycle_t'(data);
    check_cycle("CYCLE", seen, stamp);
    wb_read(REG_PC, data);
    check_word("PC", data, pc);
    wb_read(REG_INFO, data);
    check_class("INFO", insn_class_e'(data[3:0]), cls);
    check_mask("INFO", data[7:4], mask);
    check_word("INFO", data, info);
    wb_read(REG_OPERAND, data);
    check_word("OPERAND", data, model_operand(cls, insn, pc, pc_next));
    wb_write(REG_POP, '0);
  endtask

  task automatic retire_and_check(input insn_class_e cls, input insn_t insn, input xlen_t pc,
                                  input xlen_t pc_next);
    cycle_t stamp;
    cycle_t seen;
    retire(insn, pc, pc_next, stamp);
    wait_status(status_word(1, 1'b0));
    expect_head(cls, insn, pc, pc_next, stamp, seen);
  endtask

  `include "tb_rvfi_tracer_tests.svh"

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    rvfi   = '0;
    wb     = '0;
    seed   = 32'hcd0d_f0f4;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    after_reset_test();
    alu_test();
    flow_test();
    mem_sys_test();
    stamp_test();
    overflow_test();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
rvfi_pkg.sv
trace_pkg.sv
trace_decode.sv
trace_execute.sv
trace_result.sv
rvfi_tracer_top.sv
tb_rvfi_tracer.sv

//--- run.sh
#!/bin/sh
# Compile and run the trace monitor testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_rvfi_tracer -o Vtb_rvfi_tracer || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_rvfi_tracer)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }
